/* Makefile */
SIM      ?= verilator
TOP      ?= tb_compute_engine
FILELIST ?= project.f
OBJ_DIR  ?= obj_dir
FLAGS    ?= --binary --timing --timescale 1ns/100ps

.PHONY: sim clean

sim:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "RESULT: PASS"

clean:
	rm -rf $(OBJ_DIR)

/* hdl/admission_ctrl.sv */
`timescale 1ns/100ps

module admission_ctrl (
    input  logic                  clk,
    input  logic                  rst,
    input  engine_pkg::flit_t     in_flit,
    input  logic                  in_valid,
    output logic                  in_ready,
    output engine_pkg::flit_t     buf_flit,
    output logic                  buf_valid,
    input  logic                  buf_ready,
    output engine_pkg::out_flit_t det_flit,
    output logic                  det_valid,
    input  logic                  det_ready,
    input  logic                  pkt_released,
    output logic                  credit_sub
);
    import engine_pkg::*;

    admit_state_t           state;
    logic [PKT_COUNT_W-1:0] pkt_count;
    dest_t                  det_dest;
    logic                   last_fire;

    // payload goes to both paths, only valid and ready are steered
    assign buf_flit = in_flit;
    assign det_flit = '{flit: in_flit, dest: det_dest};

    always_comb begin
        buf_valid = 1'b0;
        det_valid = 1'b0;
        in_ready  = 1'b0;
        case (state)
            ADMIT_INSERT: begin
                buf_valid = in_valid;
                in_ready  = buf_ready;
            end
            ADMIT_DETOUR: begin
                det_valid = in_valid;
                in_ready  = det_ready;
            end
            default: ;
        endcase
    end

    assign last_fire  = in_valid && in_ready && in_flit.last;
    assign credit_sub = (state == ADMIT_INSERT) && last_fire;

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= ADMIT_IDLE;
            pkt_count <= '0;
            det_dest  <= DEST_DETOUR_LO;
        end else begin
            case (state)
                ADMIT_IDLE: begin
                    // decide on the head flit, one cycle
                    if (in_valid) begin
                        if (pkt_count < PKT_COUNT_W'(INIT_CREDIT_NUM)) begin
                            state <= ADMIT_INSERT;
                        end else begin
                            state    <= ADMIT_DETOUR;
                            det_dest <= in_flit.data[DESC_PORT_BIT] ? DEST_DETOUR_HI
                                                                    : DEST_DETOUR_LO;
                        end
                    end
                end
                default: begin
                    if (last_fire) begin
                        state <= ADMIT_IDLE;
                    end
                end
            endcase

            if (credit_sub && !pkt_released) begin
                pkt_count <= pkt_count + 1'b1;
            end else if (pkt_released && !credit_sub) begin
                pkt_count <= pkt_count - 1'b1;
            end
        end
    end

endmodule

/* hdl/compute_engine.sv */
`timescale 1ns/100ps

module compute_engine (
    input  logic                     clk,
    input  logic                     rst,
    input  engine_pkg::flit_t        in_flit,
    input  logic                     in_valid,
    output logic                     in_ready,
    output engine_pkg::out_flit_t    out_flit,
    output logic                     out_valid,
    input  logic                     out_ready,
    output engine_pkg::credit_ctrl_t credit
);
    import engine_pkg::*;

    flit_t     fifo_flit;
    logic      fifo_valid;
    logic      fifo_ready;
    flit_t     buf_in_flit;
    logic      buf_in_valid;
    logic      buf_in_ready;
    flit_t     buf_out_flit;
    logic      buf_out_valid;
    logic      buf_out_ready;
    out_flit_t det_flit;
    logic      det_valid;
    logic      det_ready;
    out_flit_t cmp_flit;
    logic      cmp_valid;
    logic      cmp_ready;
    logic      credit_sub;
    logic      credit_add;

    assign credit = '{sub: credit_sub, add: credit_add};

    flit_fifo #(.DEPTH(IN_DEPTH)) i_in_fifo (
        .clk(clk), .rst(rst),
        .in_flit(in_flit), .in_valid(in_valid), .in_ready(in_ready),
        .out_flit(fifo_flit), .out_valid(fifo_valid), .out_ready(fifo_ready)
    );

    admission_ctrl i_admit (
        .clk(clk), .rst(rst),
        .in_flit(fifo_flit), .in_valid(fifo_valid), .in_ready(fifo_ready),
        .buf_flit(buf_in_flit), .buf_valid(buf_in_valid), .buf_ready(buf_in_ready),
        .det_flit(det_flit), .det_valid(det_valid), .det_ready(det_ready),
        .pkt_released(credit_add), .credit_sub(credit_sub)
    );

    // holds up to two buffered packets
    flit_fifo #(.DEPTH(BUF_DEPTH)) i_pkt_buf (
        .clk(clk), .rst(rst),
        .in_flit(buf_in_flit), .in_valid(buf_in_valid), .in_ready(buf_in_ready),
        .out_flit(buf_out_flit), .out_valid(buf_out_valid), .out_ready(buf_out_ready)
    );

    compute_fsm i_compute (
        .clk(clk), .rst(rst),
        .buf_flit(buf_out_flit), .buf_valid(buf_out_valid), .buf_ready(buf_out_ready),
        .cmp_flit(cmp_flit), .cmp_valid(cmp_valid), .cmp_ready(cmp_ready),
        .credit_add(credit_add)
    );

    egress_arbiter i_arb (
        .clk(clk), .rst(rst),
        .det_flit(det_flit), .det_valid(det_valid), .det_ready(det_ready),
        .cmp_flit(cmp_flit), .cmp_valid(cmp_valid), .cmp_ready(cmp_ready),
        .out_flit(out_flit), .out_valid(out_valid), .out_ready(out_ready)
    );

endmodule

/* hdl/compute_fsm.sv */
`timescale 1ns/100ps

module compute_fsm (
    input  logic                  clk,
    input  logic                  rst,
    input  engine_pkg::flit_t     buf_flit,
    input  logic                  buf_valid,
    output logic                  buf_ready,
    output engine_pkg::out_flit_t cmp_flit,
    output logic                  cmp_valid,
    input  logic                  cmp_ready,
    output logic                  credit_add
);
    import engine_pkg::*;

    localparam int ITEM_W = $bits(chain_item_t);

    compute_state_t state;
    desc_time_t     head_time;
    desc_chain_t    next_chain;
    chain_item_t    next_item;
    flit_data_t     head_data;
    dest_t          head_dest;
    dest_t          dest_q;
    logic           egress;
    logic           timer_load;
    logic           timer_done;
    logic           fire;

    assign head_time = buf_flit.data[DESC_TIME_LSB +: $bits(desc_time_t)];

    // drop the current hop, next item picks the destination
    always_comb begin
        next_chain = buf_flit.data[DESC_CHAIN_LSB +: $bits(desc_chain_t)] >> ITEM_W;
        next_item  = next_chain[ITEM_W-1:0];
        head_dest  = (next_item == '0) ? DEST_DMA : next_item[$bits(dest_t)-1:0];
        head_data  = buf_flit.data;
        head_data[DESC_CHAIN_LSB +: $bits(desc_chain_t)] = next_chain;
    end

    assign egress     = (state == CMP_EGRESS_HEAD) || (state == CMP_EGRESS_DATA);
    assign cmp_valid  = egress && buf_valid;
    assign buf_ready  = egress && cmp_ready;
    assign fire       = cmp_valid && cmp_ready;
    assign credit_add = fire && buf_flit.last;

    always_comb begin
        cmp_flit.flit.last = buf_flit.last;
        if (state == CMP_EGRESS_HEAD) begin
            cmp_flit.flit.data = head_data;
            cmp_flit.dest      = head_dest;
        end else begin
            cmp_flit.flit.data = buf_flit.data;
            cmp_flit.dest      = dest_q;
        end
    end

    assign timer_load = (state == CMP_IDLE) && buf_valid;

    delay_timer i_timer (
        .clk        (clk),
        .rst        (rst),
        .load       (timer_load),
        .load_value (head_time),
        .done       (timer_done)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            state  <= CMP_IDLE;
            dest_q <= DEST_DMA;
        end else begin
            case (state)
                CMP_IDLE: begin
                    if (buf_valid) begin
                        state <= (head_time == '0) ? CMP_EGRESS_HEAD : CMP_BUSY;
                    end
                end
                CMP_BUSY: begin
                    if (timer_done) begin
                        state <= CMP_EGRESS_HEAD;
                    end
                end
                CMP_EGRESS_HEAD: begin
                    if (fire) begin
                        dest_q <= head_dest;
                        // a single-flit packet ends on its head
                        state  <= buf_flit.last ? CMP_IDLE : CMP_EGRESS_DATA;
                    end
                end
                default: begin
                    if (credit_add) begin
                        state <= CMP_IDLE;
                    end
                end
            endcase
        end
    end

endmodule

/* hdl/delay_timer.sv */
`timescale 1ns/100ps

module delay_timer (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   load,
    input  engine_pkg::desc_time_t load_value,
    output logic                   done
);
    import engine_pkg::*;

    desc_time_t count;

    assign done = (count == '0);

    // counts down once per cycle and sticks at zero
    always_ff @(posedge clk) begin
        if (rst) begin
            count <= '0;
        end else if (load) begin
            count <= load_value;
        end else if (!done) begin
            count <= count - 1'b1;
        end
    end

endmodule

/* hdl/egress_arbiter.sv */
`timescale 1ns/100ps

module egress_arbiter (
    input  logic                  clk,
    input  logic                  rst,
    input  engine_pkg::out_flit_t det_flit,
    input  logic                  det_valid,
    output logic                  det_ready,
    input  engine_pkg::out_flit_t cmp_flit,
    input  logic                  cmp_valid,
    output logic                  cmp_ready,
    output engine_pkg::out_flit_t out_flit,
    output logic                  out_valid,
    input  logic                  out_ready
);
    // select 0 is the detour input, 1 the compute input
    logic locked;
    logic sel_q;
    logic prio_cmp;
    logic pick;
    logic sel;
    logic out_fire;

    // round robin only matters when both request
    assign pick = (det_valid && cmp_valid) ? prio_cmp : cmp_valid;
    assign sel  = locked ? sel_q : pick;

    assign out_flit  = sel ? cmp_flit : det_flit;
    assign out_valid = sel ? cmp_valid : det_valid;
    assign det_ready = out_ready && !sel;
    assign cmp_ready = out_ready && sel;
    assign out_fire  = out_valid && out_ready;

    always_ff @(posedge clk) begin
        if (rst) begin
            locked   <= 1'b0;
            sel_q    <= 1'b0;
            prio_cmp <= 1'b0;
        end else begin
            if (out_fire && out_flit.flit.last) begin
                locked   <= 1'b0;
                prio_cmp <= !sel;
            end else if (!locked && out_valid) begin
                // lock as soon as a packet is offered so the output stays stable
                locked <= 1'b1;
                sel_q  <= pick;
            end
        end
    end

endmodule

/* hdl/engine_pkg.sv */
package engine_pkg;

    // payload and descriptor vectors
    typedef logic [63:0] flit_data_t;
    typedef logic [2:0]  dest_t;
    typedef logic [3:0]  chain_item_t;
    typedef logic [15:0] desc_chain_t;
    typedef logic [15:0] desc_time_t;

    // head flit field positions
    localparam int DESC_CHAIN_LSB = 0;
    localparam int DESC_TIME_LSB  = 16;
    localparam int DESC_PORT_BIT  = 32;

    // packet buffer admits this many packets
    localparam int unsigned INIT_CREDIT_NUM = 2;
    localparam int PKT_COUNT_W = 2;
    localparam int BUF_DEPTH   = 32;
    localparam int IN_DEPTH    = 4;

    localparam dest_t DEST_DMA       = 3'd1;
    localparam dest_t DEST_DETOUR_LO = 3'd0;
    localparam dest_t DEST_DETOUR_HI = 3'd3;

    typedef struct packed {
        flit_data_t data;
        logic       last;
    } flit_t;

    typedef struct packed {
        flit_t flit;
        dest_t dest;
    } out_flit_t;

    typedef struct packed {
        logic sub;
        logic add;
    } credit_ctrl_t;

    typedef enum logic [1:0] {ADMIT_IDLE, ADMIT_INSERT, ADMIT_DETOUR} admit_state_t;

    typedef enum logic [1:0] {
        CMP_IDLE,
        CMP_BUSY,
        CMP_EGRESS_HEAD,
        CMP_EGRESS_DATA
    } compute_state_t;

endpackage

/* hdl/flit_fifo.sv */
`timescale 1ns/100ps

module flit_fifo #(
    parameter int DEPTH = 4
) (
    input  logic              clk,
    input  logic              rst,
    input  engine_pkg::flit_t in_flit,
    input  logic              in_valid,
    output logic              in_ready,
    output engine_pkg::flit_t out_flit,
    output logic              out_valid,
    input  logic              out_ready
);
    import engine_pkg::*;

    localparam int AW = $clog2(DEPTH);
    localparam logic [AW:0] FULL_COUNT = (AW+1)'(DEPTH);

    flit_t         mem [DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [AW:0]   count;
    logic [AW:0]   count_next;
    logic          push;
    logic          pop;

    assign push      = in_valid && in_ready;
    assign pop       = out_valid && out_ready;
    assign out_valid = (count != '0);
    assign out_flit  = mem[rd_ptr];

    always_comb begin
        count_next = count;
        if (push && !pop) begin
            count_next = count + 1'b1;
        end else if (pop && !push) begin
            count_next = count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= in_flit;
        end
    end

    // ready follows the next occupancy and is low through reset
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            in_ready <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count    <= count_next;
            in_ready <= (count_next != FULL_COUNT);
        end
    end

endmodule

/* project.f */
hdl/engine_pkg.sv
hdl/flit_fifo.sv
hdl/admission_ctrl.sv
hdl/delay_timer.sv
hdl/compute_fsm.sv
hdl/egress_arbiter.sv
hdl/compute_engine.sv
verif/tb_compute_engine.sv

/* verif/tb_compute_engine.sv */
`timescale 1ns/100ps

module tb_compute_engine;
    import engine_pkg::*;

    localparam int NUM_PKTS   = 14;
    localparam int WAIT_LIMIT = 4000;
    localparam int unsigned SEED = 32'h49c2_623d;

    localparam logic [1:0] MODE_HIGH = 2'd0;
    localparam logic [1:0] MODE_LOW  = 2'd1;
    localparam logic [1:0] MODE_RAND = 2'd2;
    localparam logic [1:0] ROUTE_CMP = 2'd0;
    localparam logic [1:0] ROUTE_DET = 2'd1;
    localparam logic [1:0] ROUTE_ANY = 2'd2;

    typedef struct packed {
        logic [7:0]  id;
        logic [3:0]  test;
        logic [3:0]  len;
        desc_chain_t chain;
        desc_time_t  time_val;
        logic        port;
        logic [1:0]  mode;
        logic [1:0]  route;
    } pkt_entry_t;

    logic         clk;
    logic         rst;
    flit_t        in_flit;
    logic         in_valid;
    logic         in_ready;
    out_flit_t    out_flit;
    logic         out_valid;
    logic         out_ready;
    credit_ctrl_t credit;

    pkt_entry_t pkts [NUM_PKTS];
    logic       seen [NUM_PKTS];
    logic [1:0] out_mode;
    int         errors = 0;
    int         tests_failed = 0;
    int         sub_total = 0;
    int         add_total = 0;
    int         cmp_total = 0;
    int         last_cmp_id = 0;
    // output packet being collected
    logic       in_pkt = 1'b0;
    int         cur_idx;
    int         beat_idx;
    dest_t      cur_dest;
    logic       cur_cmp;

    compute_engine i_dut (
        .clk       (clk),
        .rst       (rst),
        .in_flit   (in_flit),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .out_flit  (out_flit),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .credit    (credit)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // columns: id, test, len, chain, time, port, out_ready mode, route
    task automatic load_table();
        pkts[0]  = '{8'd1,  4'd2, 4'd3, 16'h0052, 16'd0,  1'b0, MODE_HIGH, ROUTE_CMP};
        pkts[1]  = '{8'd2,  4'd3, 4'd2, 16'h0004, 16'd0,  1'b1, MODE_HIGH, ROUTE_CMP};
        pkts[2]  = '{8'd3,  4'd4, 4'd3, 16'h0763, 16'd9,  1'b0, MODE_HIGH, ROUTE_CMP};
        pkts[3]  = '{8'd4,  4'd4, 4'd2, 16'h0036, 16'd2,  1'b1, MODE_HIGH, ROUTE_CMP};
        pkts[4]  = '{8'd5,  4'd4, 4'd4, 16'h0027, 16'd5,  1'b0, MODE_HIGH, ROUTE_ANY};
        pkts[5]  = '{8'd6,  4'd5, 4'd3, 16'h0075, 16'd0,  1'b0, MODE_LOW,  ROUTE_CMP};
        pkts[6]  = '{8'd7,  4'd5, 4'd2, 16'h0046, 16'd3,  1'b1, MODE_LOW,  ROUTE_CMP};
        pkts[7]  = '{8'd8,  4'd5, 4'd2, 16'h0062, 16'd1,  1'b1, MODE_LOW,  ROUTE_DET};
        pkts[8]  = '{8'd9,  4'd6, 4'd1, 16'h0345, 16'd0,  1'b1, MODE_RAND, ROUTE_ANY};
        pkts[9]  = '{8'd10, 4'd6, 4'd5, 16'h0017, 16'd4,  1'b0, MODE_RAND, ROUTE_ANY};
        pkts[10] = '{8'd11, 4'd6, 4'd2, 16'h0002, 16'd0,  1'b1, MODE_RAND, ROUTE_ANY};
        pkts[11] = '{8'd12, 4'd6, 4'd3, 16'h0561, 16'd12, 1'b0, MODE_RAND, ROUTE_ANY};
        pkts[12] = '{8'd13, 4'd6, 4'd1, 16'h0073, 16'd1,  1'b1, MODE_RAND, ROUTE_ANY};
        pkts[13] = '{8'd14, 4'd6, 4'd4, 16'h0024, 16'd7,  1'b0, MODE_RAND, ROUTE_ANY};
    endtask

    function automatic flit_data_t payload(input logic [7:0] id, input int idx);
        logic [7:0] ib;
        ib = 8'(idx);
        return {id, ib, 16'hd00d ^ {id, ib}, 32'h1357_9bdf + {16'd0, id, ib}};
    endfunction

    // id on top, filler, then port, time and chain in their descriptor slots
    function automatic flit_data_t head_data(input pkt_entry_t e);
        return {e.id, 23'h2a_5c33 ^ {15'd0, e.id}, e.port, e.time_val, e.chain};
    endfunction

    function automatic flit_data_t shifted_head(input pkt_entry_t e);
        flit_data_t d;
        d = head_data(e);
        d[15:0] = {4'h0, e.chain[15:4]};
        return d;
    endfunction

    function automatic dest_t computed_dest(input pkt_entry_t e);
        if (e.chain[7:4] == 4'h0) begin
            return DEST_DMA;
        end
        return e.chain[6:4];
    endfunction

    function automatic logic group_done(input int t);
        for (int i = 0; i < NUM_PKTS; i++) begin
            if (int'(pkts[i].test) == t && !seen[i]) begin
                return 1'b0;
            end
        end
        return 1'b1;
    endfunction

    task automatic check_flit(input string name, input flit_data_t got, input flit_data_t exp);
        if (got !== exp) begin
            $display("ERR %s: got 0x%h exp 0x%h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_dest(input string name, input dest_t got, input dest_t exp);
        if (got !== exp) begin
            $display("ERR %s: got 0x%h exp 0x%h", name, got, exp);
            errors++;
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("ERR %s: got 0x%h exp 0x%h", name, got, exp);
            errors++;
        end
    endtask

    task automatic abort_run(input string what);
        $display("%s", what);
        $display("RESULT: FAIL");
        $finish;
    endtask

    // one output beat, packets stay contiguous on the output
    task automatic take_beat();
        pkt_entry_t e;
        string      tag;
        if (!in_pkt) begin
            in_pkt   = 1'b1;
            beat_idx = 0;
            cur_idx  = int'(out_flit.flit.data[63:56]) - 1;
            if (cur_idx < 0 || cur_idx >= NUM_PKTS || seen[cur_idx]) begin
                $display("unknown or repeated packet id %0d on the output", cur_idx + 1);
                errors++;
                cur_idx = -1;
            end else begin
                e = pkts[cur_idx];
                tag = $sformatf("out_flit.flit.data pkt %0d head", e.id);
                cur_cmp = (e.route == ROUTE_CMP) ||
                          (e.route == ROUTE_ANY && out_flit.flit.data[15:0] != e.chain);
                if (cur_cmp) begin
                    cur_dest = computed_dest(e);
                    check_flit(tag, out_flit.flit.data, shifted_head(e));
                    if (int'(e.id) < last_cmp_id) begin
                        $display("computed packet %0d left after packet %0d", e.id, last_cmp_id);
                        errors++;
                    end
                    last_cmp_id = int'(e.id);
                    cmp_total++;
                end else begin
                    cur_dest = e.port ? DEST_DETOUR_HI : DEST_DETOUR_LO;
                    check_flit(tag, out_flit.flit.data, head_data(e));
                end
            end
        end else if (cur_idx >= 0) begin
            tag = $sformatf("out_flit.flit.data pkt %0d beat %0d", cur_idx + 1, beat_idx);
            check_flit(tag, out_flit.flit.data, payload(pkts[cur_idx].id, beat_idx));
        end
        if (cur_idx >= 0) begin
            check_dest($sformatf("out_flit.dest pkt %0d", cur_idx + 1), out_flit.dest, cur_dest);
        end
        if (out_flit.flit.last) begin
            in_pkt = 1'b0;
            if (cur_idx >= 0) begin
                check_count("packet length", beat_idx + 1, int'(pkts[cur_idx].len));
                seen[cur_idx] = 1'b1;
            end
        end
        beat_idx++;
    endtask

    // output side: out_ready on the falling edge, outputs sampled once settled
    initial begin
        out_ready = 1'b0;
        forever begin
            @(negedge clk);
            if (!rst) begin
                case (out_mode)
                    MODE_HIGH: out_ready = 1'b1;
                    MODE_RAND: out_ready = ($urandom % 4) != 0;
                    default:   out_ready = 1'b0;
                endcase
                // credit.add follows out_ready through the arbiter
                #1;
                if (out_valid && out_ready) begin
                    take_beat();
                end
                if (credit.sub) begin
                    sub_total++;
                end
                if (credit.add) begin
                    add_total++;
                end
            end
        end
    end

    task automatic send_flit(input flit_t f);
        int waited;
        in_flit  = f;
        in_valid = 1'b1;
        waited   = 0;
        while (!in_ready) begin
            @(negedge clk);
            waited++;
            if (waited > WAIT_LIMIT) begin
                abort_run("input FIFO never accepted a flit");
            end
        end
        @(negedge clk);
        in_valid = 1'b0;
    endtask

    task automatic send_packet(input pkt_entry_t e);
        flit_t f;
        for (int k = 0; k < int'(e.len); k++) begin
            f.data = (k == 0) ? head_data(e) : payload(e.id, k);
            f.last = (k == int'(e.len) - 1);
            send_flit(f);
        end
    endtask

    task automatic wait_cond(input int t, input int subs, input string what);
        int waited;
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
            if (waited > WAIT_LIMIT) begin
                abort_run($sformatf("timed out waiting for %s", what));
            end
        end while (sub_total < subs || (t != 0 && !group_done(t)));
    endtask

    task automatic report_test(input int t, input string label, input int errs);
        if (errs == 0) begin
            $display("test %0d %s: ok", t, label);
        end else begin
            $display("test %0d %s: %0d errors", t, label, errs);
            tests_failed++;
        end
    endtask

    task automatic run_test(input int t, input string label);
        int err0;
        int sub0;
        int add0;
        int cmp0;
        int fixed;
        err0  = errors;
        sub0  = sub_total;
        add0  = add_total;
        cmp0  = cmp_total;
        fixed = 0;
        @(posedge clk);
        for (int i = 0; i < NUM_PKTS; i++) begin
            if (int'(pkts[i].test) == t) begin
                out_mode = pkts[i].mode;
                fixed += (pkts[i].route == ROUTE_CMP) ? 1 : 0;
            end
        end
        @(negedge clk);
        for (int i = 0; i < NUM_PKTS; i++) begin
            if (int'(pkts[i].test) == t) begin
                send_packet(pkts[i]);
            end
        end
        // stalled group, release the output once the buffer holds its packets
        if (out_mode == MODE_LOW) begin
            wait_cond(0, sub0 + fixed, "packets to enter the buffer");
            out_mode = MODE_HIGH;
        end
        wait_cond(t, 0, $sformatf("the packets of test %0d", t));
        check_count("credit.sub pulses", sub_total - sub0, cmp_total - cmp0);
        check_count("credit.add pulses", add_total - add0, cmp_total - cmp0);
        report_test(t, label, errors - err0);
    endtask

    initial begin
        int unsigned seed_val;
        int          err0;
        seed_val = $urandom(SEED);
        rst      = 1'b1;
        in_valid = 1'b0;
        in_flit  = '0;
        out_mode = MODE_LOW;
        load_table();
        foreach (seen[i]) begin
            seen[i] = 1'b0;
        end
        repeat (4) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);
        err0 = errors;
        check_count("out_valid", int'(out_valid), 0);
        check_count("credit.sub", int'(credit.sub), 0);
        check_count("credit.add", int'(credit.add), 0);
        report_test(1, "reset", errors - err0);
        run_test(2, "immediate compute");
        run_test(3, "chain exhausted");
        run_test(4, "nonzero time");
        run_test(5, "detour");
        run_test(6, "random back-pressure");
        $display("tests run 6, failed %0d, check errors %0d", tests_failed, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule
